/* src/arbiter_pkg.sv */
`default_nettype none

// Shared widths and types for the instruction/data memory arbiter
package arbiter_pkg;

    localparam int ADDR_WIDTH = 32;   // Byte address
    localparam int LINE_WIDTH = 256;  // Cache line, as the caches see it
    localparam int BEAT_WIDTH = 64;   // Physical memory data bus
    localparam int LINE_BEATS = LINE_WIDTH / BEAT_WIDTH;  // 4 beats per line

    // Byte address, client side and memory side
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Full cache line, beat 0 sits in the low bits
    typedef logic [LINE_WIDTH-1:0] line_t;

    // One transfer on the memory port
    typedef logic [BEAT_WIDTH-1:0] beat_t;

    // Position of a beat inside its line
    typedef logic [$clog2(LINE_BEATS)-1:0] beat_idx_t;

    // Arbiter FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a cache request
        BURST,  // Beats moving on the memory port
        DONE    // One-cycle resp to the granted cache
    } arb_state_t;

endpackage : arbiter_pkg

`default_nettype wire

/* src/arb_fsm.sv */
`default_nettype none

// Control for the two-client memory arbiter
module arb_fsm (
    input  logic clk,
    input  logic rst,
    input  logic instr_read,
    input  logic instr_write,
    input  logic data_read,
    input  logic data_write,
    input  logic pmem_resp,
    input  logic last_beat,   // From beat_counter, high on the final beat
    output logic grant_load,  // One pulse on the edge leaving IDLE
    output logic grant_data,  // 1 selects the data cache
    output logic pmem_read,
    output logic pmem_write,
    output logic instr_resp,
    output logic data_resp
);

    arbiter_pkg::arb_state_t state, next_state;

    logic served_data;  // Client of the current or most recent transaction
    logic op_write;     // Latched operation of the granted client
    logic instr_req;
    logic data_req;
    logic pick_data;    // Grant choice while sitting in IDLE

    assign instr_req = instr_read | instr_write;
    assign data_req  = data_read | data_write;

    // Data wins if alone, or if both ask and instr was served last
    assign pick_data = data_req & (~instr_req | ~served_data);

    assign grant_load = (state == arbiter_pkg::IDLE) && (instr_req || data_req);
    // Live choice in IDLE so request_mux latches the right port on the grant edge
    assign grant_data = (state == arbiter_pkg::IDLE) ? pick_data : served_data;

    assign pmem_read  = (state == arbiter_pkg::BURST) && !op_write;
    assign pmem_write = (state == arbiter_pkg::BURST) && op_write;

    assign instr_resp = (state == arbiter_pkg::DONE) && !served_data;
    assign data_resp  = (state == arbiter_pkg::DONE) && served_data;

    always_comb begin
        next_state = state;
        unique case (state)
            arbiter_pkg::IDLE:  if (grant_load) next_state = arbiter_pkg::BURST;
            arbiter_pkg::BURST: if (pmem_resp && last_beat) next_state = arbiter_pkg::DONE;
            arbiter_pkg::DONE:  next_state = arbiter_pkg::IDLE;  // Client drops request now
            default:            next_state = arbiter_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= arbiter_pkg::IDLE;
            served_data <= 1'b1;  // So instr gets the first tie
            op_write    <= 1'b0;
        end else begin
            state <= next_state;
            if (grant_load) begin
                served_data <= pick_data;
                op_write    <= pick_data ? data_write : instr_write;
            end
        end
    end

    // One direction at a time on the memory port
    a_pmem_onehot: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write));

    // Only the granted cache sees resp
    a_resp_onehot: assert property (@(posedge clk) disable iff (rst)
        !(instr_resp && data_resp));

endmodule : arb_fsm

`default_nettype wire

/* src/beat_counter.sv */
`default_nettype none

// Beat position within the current burst
module beat_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,      // Grant edge starts a new line
    input  logic                   pmem_resp,  // One per accepted beat
    output arbiter_pkg::beat_idx_t beat,
    output logic                   last_beat
);

    logic burst_done;  // Final beat seen, nothing more due until next clear

    assign last_beat = (beat == arbiter_pkg::beat_idx_t'(arbiter_pkg::LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat       <= '0;
            burst_done <= 1'b0;
        end else if (clear) begin
            beat       <= '0;
            burst_done <= 1'b0;
        end else if (pmem_resp) begin
            beat <= beat + 1'b1;  // Wraps to 0 after the last beat
            if (last_beat)
                burst_done <= 1'b1;
        end
    end

    // Memory must not overrun the line
    a_no_extra_beat: assert property (@(posedge clk) disable iff (rst)
        (burst_done && !clear) |-> !pmem_resp);

endmodule : beat_counter

`default_nettype wire

/* src/request_mux.sv */
`default_nettype none

// Holds the granted request steady on the memory port
module request_mux (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   grant_load,
    input  logic                   grant_data,
    input  arbiter_pkg::addr_t     instr_address,
    input  arbiter_pkg::addr_t     data_address,
    input  arbiter_pkg::line_t     instr_wline,
    input  arbiter_pkg::line_t     data_wline,
    input  arbiter_pkg::beat_idx_t beat,
    output arbiter_pkg::addr_t     pmem_address,
    output arbiter_pkg::beat_t     pmem_wdata
);

    // Clears the byte offset within a line
    localparam arbiter_pkg::addr_t LINE_MASK =
        ~arbiter_pkg::addr_t'(arbiter_pkg::LINE_WIDTH / 8 - 1);

    arbiter_pkg::addr_t addr_q;
    arbiter_pkg::line_t wline_q;

    always_ff @(posedge clk) begin
        if (rst)
            addr_q <= '0;
        else if (grant_load)
            addr_q <= (grant_data ? data_address : instr_address) & LINE_MASK;
    end

    // Write data, only meaningful on write bursts
    always_ff @(posedge clk) begin
        if (grant_load)
            wline_q <= grant_data ? data_wline : instr_wline;
    end

    assign pmem_address = addr_q;
    // Counter steps after each pmem_resp, so the next beat is up one cycle later
    assign pmem_wdata = wline_q[beat*arbiter_pkg::BEAT_WIDTH +: arbiter_pkg::BEAT_WIDTH];

endmodule : request_mux

`default_nettype wire

/* src/line_assembler.sv */
`default_nettype none

// Builds a read line from memory beats
module line_assembler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,     // Read burst beat accepted
    input  arbiter_pkg::beat_idx_t beat,        // Slot for this beat
    input  arbiter_pkg::beat_t     pmem_rdata,
    output arbiter_pkg::line_t     rline
);

    arbiter_pkg::line_t line_q;

    // Beat k lands in bits [64k +: 64]
    always_ff @(posedge clk) begin
        if (rst)
            line_q <= '0;
        else if (capture)
            line_q[beat*arbiter_pkg::BEAT_WIDTH +: arbiter_pkg::BEAT_WIDTH] <= pmem_rdata;
    end

    // Full line is in place by the DONE cycle
    // Shared by both caches, each qualifies it with its own resp
    assign rline = line_q;

endmodule : line_assembler

`default_nettype wire

/* src/mem_arbiter.sv */
`default_nettype none

// Instruction and data caches sharing one burst memory port
module mem_arbiter (
    input  logic               clk,
    input  logic               rst,

    // Instruction cache
    input  arbiter_pkg::addr_t instr_address,
    input  arbiter_pkg::line_t instr_wline,
    input  logic               instr_read,
    input  logic               instr_write,
    output arbiter_pkg::line_t instr_rline,
    output logic               instr_resp,

    // Data cache
    input  arbiter_pkg::addr_t data_address,
    input  arbiter_pkg::line_t data_wline,
    input  logic               data_read,
    input  logic               data_write,
    output arbiter_pkg::line_t data_rline,
    output logic               data_resp,

    // Physical memory, 64-bit beats
    input  arbiter_pkg::beat_t pmem_rdata,
    input  logic               pmem_resp,
    output arbiter_pkg::addr_t pmem_address,
    output arbiter_pkg::beat_t pmem_wdata,
    output logic               pmem_read,
    output logic               pmem_write
);

    logic                   grant_load;
    logic                   grant_data;
    logic                   last_beat;
    arbiter_pkg::beat_idx_t beat;
    arbiter_pkg::line_t     rline;

    arb_fsm u_fsm (
        .clk, .rst,
        .instr_read, .instr_write, .data_read, .data_write,
        .pmem_resp, .last_beat,
        .grant_load, .grant_data,
        .pmem_read, .pmem_write,
        .instr_resp, .data_resp
    );

    beat_counter u_count (
        .clk, .rst,
        .clear     (grant_load),
        .pmem_resp,
        .beat, .last_beat
    );

    request_mux u_req (
        .clk, .rst,
        .grant_load, .grant_data,
        .instr_address, .data_address,
        .instr_wline, .data_wline,
        .beat,
        .pmem_address, .pmem_wdata
    );

    line_assembler u_line (
        .clk, .rst,
        .capture    (pmem_read & pmem_resp),  // Read beats only
        .beat,
        .pmem_rdata,
        .rline
    );

    assign instr_rline = rline;
    assign data_rline  = rline;

endmodule : mem_arbiter

`default_nettype wire

/* tb/pmem_model.sv */
`default_nettype none

// Physical memory model, 64-bit beats in bursts of one line
module pmem_model (
    input  logic               clk,
    input  logic               rst,
    input  arbiter_pkg::addr_t pmem_address,  // Line-aligned, steady for the burst
    input  arbiter_pkg::beat_t pmem_wdata,
    input  logic               pmem_read,
    input  logic               pmem_write,
    output arbiter_pkg::beat_t pmem_rdata,
    output logic               pmem_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam arbiter_pkg::beat_t FILL_KEY = 64'h9e37_79b9_7f4a_7c15;

    arbiter_pkg::beat_t mem [arbiter_pkg::addr_t];  // Written beats only
    integer             seed = 32'h237af616;
    logic [2:0]         beat_n;     // Beats accepted so far in this burst
    logic [1:0]         wait_left;  // Wait cycles before the next beat
    arbiter_pkg::addr_t beat_addr;

    assign beat_addr = pmem_address + (arbiter_pkg::addr_t'(beat_n) << 3);

    // Untouched beats read back as their own byte address XOR a key
    function automatic arbiter_pkg::beat_t read_beat(arbiter_pkg::addr_t a);
        if (mem.exists(a))
            return mem[a];
        return {32'h0, a} ^ FILL_KEY;
    endfunction

    initial begin
        pmem_resp  <= 1'b0;
        pmem_rdata <= '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            pmem_resp <= 1'b0;
            beat_n    <= '0;
            wait_left <= 2'($random(seed));
        end else begin
            pmem_resp <= 1'b0;  // One cycle per beat
            if (!(pmem_read || pmem_write)) begin
                beat_n    <= '0;
                wait_left <= 2'($random(seed));
            end else if (pmem_resp) begin
                beat_n    <= beat_n + 1'b1;  // Arbiter took the beat
                wait_left <= 2'($random(seed));
            end else if (beat_n < 3'(arbiter_pkg::LINE_BEATS)) begin
                if (wait_left != 2'd0) begin
                    wait_left <= wait_left - 1'b1;
                end else begin
                    pmem_resp <= 1'b1;
                    if (pmem_write)
                        mem[beat_addr] = pmem_wdata;  // Beat on the bus this cycle
                    else
                        pmem_rdata <= read_beat(beat_addr);
                end
            end
            // Silent after the fourth beat until read/write drop
        end
    end

endmodule : pmem_model

`default_nettype wire

/* tb/tb_mem_arbiter.sv */
`default_nettype none

// Two cache drivers against the arbiter and a burst memory model
module tb_mem_arbiter;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TXN = 24;     // Per cache
    localparam int N_LINES = 16;   // Lines in the test window
    localparam int WATCHDOG_CYCLES = 200 * 2 * N_TXN;
    localparam arbiter_pkg::addr_t LINE_BASE = 32'h8000_0000;
    localparam arbiter_pkg::beat_t FILL_KEY = 64'h9e37_79b9_7f4a_7c15;  // Memory fill key

    logic clk = 1'b0;
    logic rst;
    arbiter_pkg::addr_t instr_address, data_address, pmem_address;
    arbiter_pkg::line_t instr_wline, data_wline, instr_rline, data_rline;
    logic               instr_read, instr_write, instr_resp;
    logic               data_read, data_write, data_resp;
    arbiter_pkg::beat_t pmem_rdata, pmem_wdata;
    logic               pmem_read, pmem_write, pmem_resp, pmem_active;

    logic               txn_write [2][N_TXN];  // Port 0 instr, port 1 data
    arbiter_pkg::addr_t txn_addr  [2][N_TXN];
    arbiter_pkg::line_t txn_line  [2][N_TXN];
    int                 txn_gap   [2][N_TXN];  // Idle cycles before each request
    arbiter_pkg::line_t shadow [N_LINES];      // Expected memory, updated on write resp
    integer             seed = 32'h237af616;
    int                 mismatch_count = 0;
    int                 protocol_count = 0;
    int                 instr_served = 0;      // Instr transactions completed so far

    logic [2:0]         beats_seen;    // Beats of the current burst
    logic               fourth_q;      // Fourth beat accepted on the last edge
    logic               active_q;
    logic               both_req_q;    // Both caches asked in the previous cycle
    logic               tie_at_grant;  // Current burst won over a waiting cache
    logic               last_data;     // Last resp went to the data cache
    logic               seen_req;
    arbiter_pkg::addr_t addr_q;

    always #2 clk = ~clk;

    mem_arbiter dut (.*);
    pmem_model pmem (.*);

    assign pmem_active = pmem_read | pmem_write;

    function automatic arbiter_pkg::line_t fill_line(arbiter_pkg::addr_t a);
        arbiter_pkg::line_t l;
        int k;
        for (k = 0; k < arbiter_pkg::LINE_BEATS; k++)
            l[k*64 +: 64] = {32'h0, a + arbiter_pkg::addr_t'(k * 8)} ^ FILL_KEY;
        return l;
    endfunction

    // Random byte offset inside the chosen line
    function automatic arbiter_pkg::addr_t pick_addr(int line_idx);
        return LINE_BASE + arbiter_pkg::addr_t'(line_idx * 32)
            + (arbiter_pkg::addr_t'($random(seed)) & 32'h1f);
    endfunction

    task automatic count_mismatch(string name, arbiter_pkg::line_t got, arbiter_pkg::line_t exp);
        mismatch_count++;
        $display("Mismatch %s: got %0h expected %0h", name, got, exp);
    endtask

    task automatic flag_violation(string what);
        protocol_count++;
        $display("Protocol error: %s", what);
    endtask

    task automatic build_stimulus();
        int p;
        int i;
        int k;
        for (p = 0; p < 2; p++) begin
            for (i = 0; i < N_TXN; i++) begin
                txn_write[p][i] = ($random(seed) & 1) != 0;
                txn_addr[p][i]  = pick_addr($random(seed) & (N_LINES - 1));
                txn_gap[p][i]   = $random(seed) & 3;  // Zero gaps give ties
                for (k = 0; k < 8; k++)
                    txn_line[p][i][k*32 +: 32] = $random(seed);
                if (i < 2) begin  // Opening on line 3, data writes then both read
                    txn_write[p][i] = (p == 1 && i == 0);
                    txn_addr[p][i]  = pick_addr(3);
                    txn_gap[p][i]   = 0;
                end
                if (p == 0 && i == 2)
                    txn_gap[p][i] = 0;  // Meets the held data request in one idle cycle
            end
        end
    endtask

    task automatic run_cache(input int port);
        int i;
        for (i = 0; i < N_TXN; i++) begin
            // Second data request waits until instr was served last, then both ask together
            if (port == 1 && i == 1)
                wait (instr_served >= 2);
            repeat (txn_gap[port][i]) @(posedge clk);
            @(posedge clk);
            if (port == 0) begin
                instr_address <= txn_addr[0][i];
                instr_wline   <= txn_line[0][i];
                instr_read    <= !txn_write[0][i];
                instr_write   <= txn_write[0][i];
            end else begin
                data_address <= txn_addr[1][i];
                data_wline   <= txn_line[1][i];
                data_read    <= !txn_write[1][i];
                data_write   <= txn_write[1][i];
            end
            do @(posedge clk); while (!(port == 0 ? instr_resp : data_resp));
            if (port == 0) begin
                instr_read  <= 1'b0;  // Drop in the cycle after resp
                instr_write <= 1'b0;
                instr_served++;
            end else begin
                data_read  <= 1'b0;
                data_write <= 1'b0;
            end
        end
    endtask

    // Reference state for the checks
    always @(posedge clk) begin
        int j;
        if (rst) begin
            for (j = 0; j < N_LINES; j++)
                shadow[j] <= fill_line(LINE_BASE + arbiter_pkg::addr_t'(j * 32));
            beats_seen   <= '0;
            fourth_q     <= 1'b0;
            active_q     <= 1'b0;
            both_req_q   <= 1'b0;
            tie_at_grant <= 1'b0;
            last_data    <= 1'b1;  // Instr wins the first tie
            seen_req     <= 1'b0;
            addr_q       <= '0;
        end else begin
            active_q   <= pmem_active;
            addr_q     <= pmem_address;
            both_req_q <= (instr_read | instr_write) & (data_read | data_write);
            fourth_q   <= pmem_active && pmem_resp
                && (beats_seen == 3'(arbiter_pkg::LINE_BEATS - 1));
            if (!pmem_active)
                beats_seen <= '0;
            else if (pmem_resp)
                beats_seen <= beats_seen + 1'b1;
            if (pmem_active && !active_q)
                tie_at_grant <= both_req_q;  // Requests seen in the IDLE cycle of the grant
            if (instr_resp)
                last_data <= 1'b0;
            if (data_resp)
                last_data <= 1'b1;
            if (instr_read | instr_write | data_read | data_write)
                seen_req <= 1'b1;
            if (instr_resp && instr_write)
                shadow[instr_address[8:5]] <= instr_wline;
            if (data_resp && data_write)
                shadow[data_address[8:5]] <= data_wline;
        end
    end

    a_instr_rline: assert property (@(posedge clk) disable iff (rst)
        (instr_resp && instr_read) |-> instr_rline == shadow[instr_address[8:5]])
        else count_mismatch("instr_rline", instr_rline, shadow[instr_address[8:5]]);
    a_data_rline: assert property (@(posedge clk) disable iff (rst)
        (data_resp && data_read) |-> data_rline == shadow[data_address[8:5]])
        else count_mismatch("data_rline", data_rline, shadow[data_address[8:5]]);
    a_resp_owner: assert property (@(posedge clk) disable iff (rst)
        (!instr_resp || instr_read || instr_write) && (!data_resp || data_read || data_write))
        else flag_violation("resp raised to a cache with no outstanding request");
    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        (instr_resp || data_resp) |=> !(instr_resp || data_resp))
        else flag_violation("resp held longer than one cycle");
    a_resp_timing: assert property (@(posedge clk) disable iff (rst)
        (instr_resp || data_resp) == fourth_q)
        else flag_violation("resp not exactly one cycle after the fourth memory beat");
    // Tie winner must differ from the last served cache
    a_alternate: assert property (@(posedge clk) disable iff (rst)
        ((instr_resp || data_resp) && tie_at_grant) |-> (data_resp != last_data))
        else flag_violation("same cache served twice in a row while the other waited");
    a_pmem_aligned: assert property (@(posedge clk) disable iff (rst)
        pmem_active |-> (pmem_address[4:0] == 5'd0 && pmem_read != pmem_write))
        else flag_violation("memory burst unaligned or with both or no direction");
    a_pmem_steady: assert property (@(posedge clk) disable iff (rst)
        (pmem_active && active_q) |-> pmem_address == addr_q)
        else count_mismatch("pmem_address", arbiter_pkg::line_t'(pmem_address),
            arbiter_pkg::line_t'(addr_q));
    a_quiet_start: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> !(instr_resp || data_resp || pmem_active))
        else flag_violation("resp or memory access before any request");

    initial begin
        instr_address <= '0;
        instr_wline   <= '0;
        instr_read    <= 1'b0;
        instr_write   <= 1'b0;
        data_address  <= '0;
        data_wline    <= '0;
        data_read     <= 1'b0;
        data_write    <= 1'b0;
        rst           <= 1'b1;
        build_stimulus();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fork
            run_cache(0);
            run_cache(1);
        join
        repeat (4) @(posedge clk);  // Let the last assertions fire
        $display("Errors: %0d mismatch, %0d protocol", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYCLES + 8) @(posedge clk);
        $display("Timeout: caches still waiting for resp after %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d mismatch, %0d protocol", mismatch_count, protocol_count);
        $display("test failed");
        $finish;
    end

endmodule : tb_mem_arbiter

`default_nettype wire

/* compile.f */
src/arbiter_pkg.sv
src/arb_fsm.sv
src/beat_counter.sv
src/request_mux.sv
src/line_assembler.sv
src/mem_arbiter.sv
tb/pmem_model.sv
tb/tb_mem_arbiter.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_mem_arbiter
RTL_TOP    ?= mem_arbiter
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= src/arbiter_pkg.sv src/arb_fsm.sv src/beat_counter.sv \
              src/request_mux.sv src/line_assembler.sv src/mem_arbiter.sv
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
